/* hw/mips_pkg.sv */
package mips_pkg;

    // --------------------
    // major opcodes
    // --------------------
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,  // funct selects the op.
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_BLEZ  = 6'h06,
        OP_BGTZ  = 6'h07,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_LBU   = 6'h24,
        OP_SB    = 6'h28,
        OP_SW    = 6'h2b,
        OP_NONE  = 6'h3f   // no control transfer this cycle.
    } opcode_e;

    // r-type function codes.
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_JR   = 6'h08,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_e;

    // --------------------
    // instruction word
    // --------------------
    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    typedef enum logic [2:0] {
        FETCH, DECODE, EXEC, MEM, WB, HALT
    } cpu_state_e;

endpackage

/* hw/exec_if.sv */
`timescale 1ns/1ps

interface exec_if import mips_pkg::*; ();

    alu_op_e     alu_op;
    logic [31:0] operand_a;
    logic [31:0] operand_b;
    logic [4:0]  shamt;
    opcode_e     branch_op;   // OP_NONE outside exec.
    logic [15:0] imm16;
    logic        pc_advance;  // one pulse per retired instruction.
    logic [31:0] alu_result;
    logic [31:0] pc;
    logic        halted;

    modport ctrl (
        output alu_op, operand_a, operand_b, shamt, branch_op, imm16, pc_advance,
        input  alu_result, pc, halted
    );

    modport dp (
        input  alu_op, operand_a, operand_b, shamt, branch_op, imm16, pc_advance,
        output alu_result, pc, halted
    );

endinterface

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data,
    output logic [31:0] v0
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;  // $zero never written.
        end
    end

    // combinational read ports.
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    // $v0 tap for the result check.
    assign v0 = regs[2];

endmodule

/* hw/alu.sv */
`timescale 1ns/1ps

module alu import mips_pkg::*; (
    exec_if.dp ex
);

    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] result;

    assign a = ex.operand_a;
    assign b = ex.operand_b;

    // --------------------
    // operation select
    // --------------------
    always_comb begin
        case (ex.alu_op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SLT: begin
                result = {31'd0, $signed(a) < $signed(b)};
            end
            ALU_SLTU: begin
                result = {31'd0, a < b};
            end
            ALU_SLL: begin
                result = b << ex.shamt;  // shifts take rt.
            end
            ALU_SRL: begin
                result = b >> ex.shamt;
            end
            ALU_LUI: begin
                result = b << 16;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign ex.alu_result = result;

endmodule

/* hw/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit import mips_pkg::*; #(
    parameter logic [31:0] RESET_VECTOR = 32'd4
) (
    input  logic clk,
    input  logic rst,
    exec_if.dp   ex
);

    logic [31:0] pc_q;
    logic [31:0] pc_plus4;
    logic [31:0] br_target;
    logic [31:0] target_q;
    logic        target_valid;  // taken branch not yet retired.
    logic        in_slot;       // delay slot is executing.
    logic        taken;
    logic        halted_q;

    assign pc_plus4  = pc_q + 32'd4;
    assign br_target = pc_plus4 + {{14{ex.imm16[15]}}, ex.imm16, 2'b00};

    // --------------------
    // branch condition
    // --------------------
    always_comb begin
        case (ex.branch_op)
            OP_BEQ:   taken = (ex.operand_a == ex.operand_b);
            OP_BNE:   taken = (ex.operand_a != ex.operand_b);
            OP_BLEZ:  taken = ($signed(ex.operand_a) <= 32'sd0);
            OP_BGTZ:  taken = ($signed(ex.operand_a) > 32'sd0);
            OP_RTYPE: taken = 1'b1;  // jr always taken.
            default:  taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (taken) begin
            target_q <= (ex.branch_op == OP_RTYPE) ? ex.operand_a : br_target;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q         <= RESET_VECTOR;
            target_valid <= 1'b0;
            in_slot      <= 1'b0;
            halted_q     <= 1'b0;
        end else begin
            if (taken) begin
                target_valid <= 1'b1;
            end
            if (ex.pc_advance) begin
                if (in_slot) begin
                    pc_q    <= target_q;  // redirect once the slot retires.
                    in_slot <= 1'b0;
                    if (target_q == 32'd0) begin
                        halted_q <= 1'b1;
                    end
                end else begin
                    pc_q         <= pc_plus4;
                    in_slot      <= target_valid;
                    target_valid <= 1'b0;
                end
            end
        end
    end

    assign ex.pc     = pc_q;
    assign ex.halted = halted_q;

endmodule

/* hw/cpu_control.sv */
`timescale 1ns/1ps

module cpu_control import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    exec_if.ctrl        ex,
    output logic [4:0]  rs_addr,
    output logic [4:0]  rt_addr,
    input  logic [31:0] rs_data,
    input  logic [31:0] rt_data,
    output logic        wr_en,
    output logic [4:0]  wr_addr,
    output logic [31:0] wr_data,
    output logic        active,
    output logic [31:0] address,
    output logic        read,
    output logic        write,
    output logic [31:0] writedata,
    output logic [3:0]  byteenable,
    input  logic [31:0] readdata,
    input  logic        waitrequest
);

    cpu_state_e  state;
    instr_u      ir;
    logic        boot;     // bus kept idle in the first cycle out of reset.
    logic [31:0] op_a_q;
    logic [31:0] op_b_q;
    logic [31:0] res_q;    // alu result, then load data.

    alu_op_e     alu_op;
    opcode_e     br_op;
    logic        use_imm;
    logic        zero_ext;
    logic        reg_wr;
    logic        mem_rd;
    logic        mem_wr;
    logic        byte_acc;
    logic [4:0]  dest;
    logic [31:0] imm_ext;
    logic [4:0]  lane_shift;
    logic [31:0] byte_lane;
    logic [31:0] load_data;
    logic [31:0] addr_raw;

    // --------------------
    // decode
    // --------------------
    always_comb begin
        alu_op   = ALU_ADD;
        br_op    = OP_NONE;
        use_imm  = 1'b1;
        zero_ext = 1'b0;
        reg_wr   = 1'b0;
        mem_rd   = 1'b0;
        mem_wr   = 1'b0;
        byte_acc = 1'b0;
        dest     = ir.i_fmt.rt;
        case (ir.i_fmt.opcode)
            OP_RTYPE: begin
                use_imm = 1'b0;
                dest    = ir.r_fmt.rd;
                reg_wr  = 1'b1;
                case (ir.r_fmt.funct)
                    F_ADDU: alu_op = ALU_ADD;
                    F_SUBU: alu_op = ALU_SUB;
                    F_AND:  alu_op = ALU_AND;
                    F_OR:   alu_op = ALU_OR;
                    F_XOR:  alu_op = ALU_XOR;
                    F_SLT:  alu_op = ALU_SLT;
                    F_SLTU: alu_op = ALU_SLTU;
                    F_SLL:  alu_op = ALU_SLL;
                    F_SRL:  alu_op = ALU_SRL;
                    F_JR: begin
                        reg_wr = 1'b0;
                        br_op  = OP_RTYPE;  // jr on the branch bus.
                    end
                    default: reg_wr = 1'b0;
                endcase
            end
            OP_ADDIU: reg_wr = 1'b1;
            OP_ANDI: begin
                alu_op   = ALU_AND;
                zero_ext = 1'b1;
                reg_wr   = 1'b1;
            end
            OP_ORI: begin
                alu_op   = ALU_OR;
                zero_ext = 1'b1;
                reg_wr   = 1'b1;
            end
            OP_LUI: begin
                alu_op = ALU_LUI;
                reg_wr = 1'b1;
            end
            OP_LW: begin
                mem_rd = 1'b1;
                reg_wr = 1'b1;
            end
            OP_LBU: begin
                mem_rd   = 1'b1;
                byte_acc = 1'b1;
                reg_wr   = 1'b1;
            end
            OP_SW: mem_wr = 1'b1;
            OP_SB: begin
                mem_wr   = 1'b1;
                byte_acc = 1'b1;
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                use_imm = 1'b0;  // compare rs against rt.
                br_op   = ir.i_fmt.opcode;
            end
            default: use_imm = 1'b1;
        endcase
    end

    assign imm_ext = zero_ext ? {16'h0000, ir.i_fmt.imm16}
                              : {{16{ir.i_fmt.imm16[15]}}, ir.i_fmt.imm16};
    assign rs_addr = ir.i_fmt.rs;
    assign rt_addr = ir.i_fmt.rt;

    // --------------------
    // state machine
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH;
            boot  <= 1'b1;
        end else begin
            boot <= 1'b0;
            case (state)
                FETCH: begin
                    if (ex.halted) begin
                        state <= HALT;
                    end else if (!boot && !waitrequest) begin
                        state <= DECODE;
                    end
                end
                DECODE: state <= EXEC;
                EXEC:   state <= (mem_rd || mem_wr) ? MEM : WB;
                MEM: begin
                    if (!waitrequest) begin
                        state <= WB;
                    end
                end
                WB:      state <= FETCH;
                HALT:    state <= HALT;  // held until reset.
                default: state <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && read && !waitrequest) begin
            ir <= readdata;
        end
        if (state == DECODE) begin
            op_a_q <= rs_data;
            op_b_q <= use_imm ? imm_ext : rt_data;
        end
        if (state == EXEC) begin
            res_q <= ex.alu_result;
        end else if (state == MEM && mem_rd && !waitrequest) begin
            res_q <= load_data;
        end
    end

    // --------------------
    // datapath side
    // --------------------
    assign ex.alu_op     = alu_op;
    assign ex.operand_a  = op_a_q;
    assign ex.operand_b  = op_b_q;
    assign ex.shamt      = ir.r_fmt.shamt;
    assign ex.imm16      = ir.i_fmt.imm16;
    assign ex.branch_op  = (state == EXEC) ? br_op : OP_NONE;
    assign ex.pc_advance = (state == WB);

    assign wr_en   = (state == WB) && reg_wr;
    assign wr_addr = dest;
    assign wr_data = res_q;
    assign active  = (state != HALT);

    // avalon master.
    assign lane_shift = {res_q[1:0], 3'b000};
    assign addr_raw   = (state == MEM) ? res_q : ex.pc;
    assign address    = {addr_raw[31:2], 2'b00};
    assign read       = (state == FETCH && !boot && !ex.halted) || (state == MEM && mem_rd);
    assign write      = (state == MEM) && mem_wr;
    assign byteenable = (state == MEM && mem_wr && byte_acc) ? (4'b0001 << res_q[1:0])
                                                             : 4'b1111;
    assign writedata  = byte_acc ? ({24'h000000, rt_data[7:0]} << lane_shift) : rt_data;
    assign byte_lane  = readdata >> lane_shift;
    assign load_data  = byte_acc ? {24'h000000, byte_lane[7:0]} : readdata;

endmodule

/* hw/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
    parameter logic [31:0] RESET_VECTOR = 32'd4
) (
    input  logic        clk,
    input  logic        rst,
    output logic        active,
    output logic [31:0] register_v0,
    output logic [31:0] address,
    output logic        read,
    output logic        write,
    output logic [31:0] writedata,
    output logic [3:0]  byteenable,
    input  logic [31:0] readdata,
    input  logic        waitrequest
);

    logic [4:0]  rs_addr;
    logic [4:0]  rt_addr;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic        wr_en;
    logic [4:0]  wr_addr;
    logic [31:0] wr_data;

    exec_if ex_bus ();

    // --------------------
    // control and datapath
    // --------------------
    cpu_control u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .ex          (ex_bus.ctrl),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .active      (active),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata),
        .waitrequest (waitrequest)
    );

    reg_file u_regs (
        .clk     (clk),
        .rst     (rst),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .v0      (register_v0)
    );

    alu u_alu (
        .ex (ex_bus.dp)
    );

    branch_unit #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_branch (
        .clk (clk),
        .rst (rst),
        .ex  (ex_bus.dp)
    );

endmodule

/* verif/avalon_ram.sv */
`timescale 1ns/1ps

module avalon_ram #(
    parameter int WORDS = 256
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        random_waits,  // stall transfers for 0 to 3 cycles.
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    input  logic [3:0]  byteenable,
    output logic [31:0] readdata,
    output logic        waitrequest
);

    localparam int AW = $clog2(WORDS);

    logic [31:0] mem [WORDS];
    logic [1:0]  wait_left;  // stall cycles left for the next transfer.
    logic [1:0]  draw;
    integer      seed;

    initial seed = 90;

    assign waitrequest = (wait_left != 2'd0);
    assign readdata    = mem[address[AW+1:2]];  // valid in the completing cycle.

    // --------------------
    // transfer handling
    // --------------------
    always @(posedge clk) begin
        if (rst) begin
            wait_left <= 2'd0;
        end else if (read || write) begin
            if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                draw = random_waits ? 2'($random(seed)) : 2'd0;
                wait_left <= draw;  // stall for the following transfer.
                if (write) begin
                    for (int i = 0; i < 4; i++) begin
                        if (byteenable[i]) begin
                            mem[address[AW+1:2]][8*i +: 8] <= writedata[8*i +: 8];
                        end
                    end
                end
            end
        end
    end

    // --------------------
    // preload and peek
    // --------------------
    task automatic clear();
        foreach (mem[i]) begin
            mem[i] = 32'h0000_0000;
        end
    endtask

    task automatic preload(input logic [31:0] byte_addr, input logic [31:0] data);
        mem[byte_addr[AW+1:2]] = data;
    endtask

    function automatic logic [31:0] word_at(input logic [31:0] byte_addr);
        return mem[byte_addr[AW+1:2]];
    endfunction

endmodule

/* verif/cpu_chk.sv */
`timescale 1ns/1ps

module cpu_chk import mips_pkg::*; (
    input logic        clk,
    input logic        rst,
    input cpu_state_e  state,
    input logic        active,
    input logic [31:0] address,
    input logic        read,
    input logic        write,
    input logic [31:0] writedata,
    input logic [3:0]  byteenable,
    input logic        waitrequest
);

    int fail_count = 0;

    // --------------------
    // avalon master rules
    // --------------------
    a_hold: assert property (@(posedge clk) disable iff (rst)
        (read || write) && waitrequest |=>
            (read || write) && $stable(address) && $stable(byteenable))
    else begin
        $error("address or byteenable changed while waitrequest held the transfer");
        fail_count++;
    end

    a_hold_data: assert property (@(posedge clk) disable iff (rst)
        write && waitrequest |=> write && $stable(writedata))
    else begin
        $error("writedata changed while waitrequest held the write");
        fail_count++;
    end

    a_one_cmd: assert property (@(posedge clk) disable iff (rst) !(read && write))
    else begin
        $error("read and write asserted together");
        fail_count++;
    end

    a_aligned: assert property (@(posedge clk) disable iff (rst)
        (read || write) |-> address[1:0] == 2'b00)
    else begin
        $error("bus address is not word aligned");
        fail_count++;
    end

    // halt is sticky until reset.
    a_halt: assert property (@(posedge clk) disable iff (rst)
        state == HALT |=> state == HALT && !active && !read && !write)
    else begin
        $error("cpu left halt or used the bus without a reset");
        fail_count++;
    end

endmodule

bind cpu_control cpu_chk chk0 (
    .clk         (clk),
    .rst         (rst),
    .state       (state),
    .active      (active),
    .address     (address),
    .read        (read),
    .write       (write),
    .writedata   (writedata),
    .byteenable  (byteenable),
    .waitrequest (waitrequest)
);

/* verif/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb import mips_pkg::*; ();

    localparam logic [31:0] RESET_VECTOR = 32'd4;
    localparam int CLK_PERIOD      = 20;
    localparam int TEST_COUNT      = 6;
    localparam int CYCLES_PER_TEST = 400;

    localparam logic [4:0] ZERO = 5'd0;
    localparam logic [4:0] V0   = 5'd2;
    localparam logic [4:0] T0   = 5'd8;
    localparam logic [4:0] T1   = 5'd9;
    localparam logic [4:0] T2   = 5'd10;
    localparam logic [4:0] T3   = 5'd11;
    localparam logic [4:0] T4   = 5'd12;
    localparam logic [4:0] T5   = 5'd13;
    localparam logic [4:0] T6   = 5'd14;
    localparam logic [4:0] T7   = 5'd15;
    localparam logic [4:0] S0   = 5'd16;
    localparam logic [4:0] S1   = 5'd17;
    localparam logic [4:0] S2   = 5'd18;
    localparam logic [4:0] S3   = 5'd19;

    logic        clk;
    logic        rst;
    logic        random_waits;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic [31:0] readdata;
    logic        waitrequest;

    logic [31:0] prog [$];
    int test_num = 0;
    int test_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int protocol_errors = 0;

    cpu_top #(.RESET_VECTOR(RESET_VECTOR)) dut0 (
        .clk(clk), .rst(rst), .active(active), .register_v0(register_v0),
        .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .readdata(readdata), .waitrequest(waitrequest)
    );

    avalon_ram ram0 (
        .clk(clk), .rst(rst), .random_waits(random_waits),
        .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .readdata(readdata), .waitrequest(waitrequest)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", TEST_COUNT * CYCLES_PER_TEST);
        $display("CHECKS FAILED");
        $finish;
    end

    // --------------------
    // program assembly
    // --------------------
    function automatic logic [31:0] r_type(funct_e fn, logic [4:0] rs, logic [4:0] rt,
                                           logic [4:0] rd, logic [4:0] shamt);
        return {OP_RTYPE, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [31:0] i_type(opcode_e op, logic [4:0] rs, logic [4:0] rt,
                                           logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic emit(logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic emit_halt();
        emit(r_type(F_JR, ZERO, ZERO, ZERO, 0));  // jr $0.
        emit(32'h0000_0000);                      // delay slot nop.
    endtask

    // taken branch over a poison add, then a not-taken one.
    task automatic emit_branch_pair(opcode_e op, logic [4:0] ta, logic [4:0] tb_,
                                    logic [4:0] na, logic [4:0] nb);
        emit(i_type(op, ta, tb_, 16'd2));
        emit(i_type(OP_ADDIU, V0, V0, 16'h0010));
        emit(i_type(OP_ADDIU, V0, V0, 16'h0400));  // must be skipped.
        emit(i_type(op, na, nb, 16'd2));
        emit(i_type(OP_ADDIU, V0, V0, 16'h0010));
        emit(i_type(OP_ADDIU, V0, V0, 16'h0008));  // fall-through path.
    endtask

    task automatic build_alu_program();
        emit(i_type(OP_ADDIU, ZERO, T0, 16'h1234));
        emit(i_type(OP_ADDIU, ZERO, T1, 16'hfffd));  // t1 = -3.
        emit(i_type(OP_LUI, ZERO, T2, 16'h8000));
        emit(i_type(OP_ORI, T2, T2, 16'h80f0));      // 0x800080f0.
        emit(r_type(F_ADDU, T0, T2, T3, 0));         // 0x80009324.
        emit(r_type(F_SUBU, T3, T1, T3, 0));         // 0x80009327.
        emit(r_type(F_AND, T3, T2, T4, 0));          // 0x80008020.
        emit(r_type(F_OR, T4, T0, T5, 0));           // 0x80009234.
        emit(r_type(F_XOR, T5, T3, T6, 0));          // 0x00000113.
        emit(r_type(F_SLT, T1, T0, T7, 0));          // 1.
        emit(r_type(F_SLTU, T1, T0, S0, 0));         // 0.
        emit(r_type(F_SLL, ZERO, T6, S1, 5'd4));     // 0x1130.
        emit(r_type(F_SRL, ZERO, T2, S2, 5'd28));    // 0x8.
        emit(i_type(OP_ANDI, T1, S3, 16'hff00));     // 0xff00.
        emit(r_type(F_ADDU, S1, S2, V0, 0));
        emit(r_type(F_ADDU, V0, T7, V0, 0));
        emit(r_type(F_ADDU, V0, S0, V0, 0));
        emit(r_type(F_XOR, V0, S3, V0, 0));          // 0xee39.
        emit_halt();
    endtask

    task automatic build_branch_program();
        emit(i_type(OP_ADDIU, ZERO, T0, 16'd5));
        emit(i_type(OP_ADDIU, ZERO, T1, 16'hffff));  // -1.
        emit(i_type(OP_ADDIU, ZERO, T2, 16'd5));
        emit_branch_pair(OP_BLEZ, T1, ZERO, T0, ZERO);
        emit_branch_pair(OP_BGTZ, T0, ZERO, T1, ZERO);
        emit_branch_pair(OP_BEQ, T0, T2, T0, T1);
        emit_branch_pair(OP_BNE, T0, T1, T0, T2);
        emit_halt();  // 8 slots of 0x10 plus 4 of 0x8 gives 0xa0.
    endtask

    task automatic build_memory_program();
        emit(i_type(OP_LUI, ZERO, T0, 16'h1234));
        emit(i_type(OP_ORI, T0, T0, 16'h5678));
        emit(i_type(OP_SW, ZERO, T0, 16'h0100));
        emit(i_type(OP_LW, ZERO, T1, 16'h0100));
        for (int lane = 0; lane < 4; lane++) begin
            emit(i_type(OP_ADDIU, ZERO, T2, 16'(32'h11 * (lane + 1))));
            emit(i_type(OP_SB, ZERO, T2, 16'(32'h108 + lane)));
        end
        emit(i_type(OP_LW, ZERO, T3, 16'h0108));   // 0x44332211.
        emit(i_type(OP_LBU, ZERO, T4, 16'h0104));  // 0xbb.
        emit(i_type(OP_LBU, ZERO, T5, 16'h0107));  // 0x88.
        emit(r_type(F_XOR, T1, T3, V0, 0));
        emit(r_type(F_ADDU, V0, T4, V0, 0));
        emit(r_type(F_SLL, ZERO, T5, T5, 5'd8));
        emit(r_type(F_ADDU, V0, T5, V0, 0));       // 0x5607fd24.
        emit_halt();
    endtask

    // --------------------
    // run control
    // --------------------
    task automatic load_program();
        ram0.clear();
        foreach (prog[i]) begin
            ram0.preload(RESET_VECTOR + 32'(i) * 4, prog[i]);
        end
        prog.delete();
    endtask

    task automatic reset_cpu();
        @(posedge clk);
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic run_to_halt();
        do @(negedge clk); while (active !== 1'b0);
    endtask

    task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic report_test(string name);
        test_num++;
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d %s: ok", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", test_num, name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        rst = 1'b1;
        random_waits = 1'b0;

        build_alu_program();
        load_program();
        reset_cpu();
        run_to_halt();
        check_word("register_v0", register_v0, 32'h0000_ee39);
        report_test("alu");

        build_branch_program();
        load_program();
        reset_cpu();
        run_to_halt();
        check_word("register_v0", register_v0, 32'h0000_00a0);
        report_test("branches");

        // stores and loads also see stalls from here on.
        @(posedge clk);
        random_waits <= 1'b1;
        build_memory_program();
        load_program();
        ram0.preload(32'h104, 32'h8899_aabb);
        reset_cpu();
        run_to_halt();
        check_word("register_v0", register_v0, 32'h5607_fd24);
        check_word("mem[0x100]", ram0.word_at(32'h100), 32'h1234_5678);
        check_word("mem[0x104]", ram0.word_at(32'h104), 32'h8899_aabb);
        check_word("mem[0x108]", ram0.word_at(32'h108), 32'h4433_2211);
        report_test("memory");

        build_branch_program();
        load_program();
        reset_cpu();
        run_to_halt();
        check_word("register_v0", register_v0, 32'h0000_00a0);
        report_test("back-pressure");

        build_alu_program();
        load_program();
        reset_cpu();
        run_to_halt();
        check_word("register_v0", register_v0, 32'h0000_ee39);
        repeat (20) begin
            @(negedge clk);
            check_word("read", 32'(read), 32'd0);
            check_word("write", 32'(write), 32'd0);
            check_word("active", 32'(active), 32'd0);
        end
        report_test("halt");

        // restart once the first delay slot has landed in $v0.
        build_branch_program();
        load_program();
        reset_cpu();
        do @(negedge clk); while (register_v0 == 32'd0);
        reset_cpu();
        run_to_halt();
        check_word("register_v0", register_v0, 32'h0000_00a0);
        report_test("mid-run reset");

        protocol_errors = dut0.u_ctrl.chk0.fail_count;
        $display("tests %0d, passed %0d, failed %0d, protocol assertion failures %0d",
                 test_num, tests_passed, tests_failed, protocol_errors);
        if (tests_failed == 0 && protocol_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* cpu_top.f */
hw/mips_pkg.sv
hw/exec_if.sv
hw/reg_file.sv
hw/alu.sv
hw/branch_unit.sv
hw/cpu_control.sv
hw/cpu_top.sv
verif/avalon_ram.sv
verif/cpu_chk.sv
verif/cpu_tb.sv
